/* design/archMapPkg.sv */
package archMapPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register file sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int NUM_LOGICAL = 32;                 // architectural registers.
  localparam int LOG_W = $clog2(NUM_LOGICAL);      // 5 bits of logical index.
  localparam int NUM_PHYS = 128;                   // physical register file depth.
  localparam int PHYS_W = $clog2(NUM_PHYS);        // 7 bits of physical index.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // retire and recovery
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // four retire slots, same as the rename table write ports.
  localparam int COMMIT_W = 4;

  // one walk cycle per group of four mappings.
  localparam int WALK_CYCLES = NUM_LOGICAL / COMMIT_W;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [LOG_W-1:0] logReg_t;    // logical register index.
  typedef logic [PHYS_W-1:0] physReg_t;  // physical register index.

  // recovery walk fsm.
  typedef enum logic {
    WALK_IDLE,  // commits update the table.
    WALK_RUN    // table streams out to the rename map.
  } walkState_t;

endpackage

/* design/archMapRam.sv */
`timescale 1ns/10ps

module archMapRam (
  input  logic                 clk,
  input  logic                 reset,
  // read ports, combinational.
  input  archMapPkg::logReg_t  readAddr0_i,
  input  archMapPkg::logReg_t  readAddr1_i,
  input  archMapPkg::logReg_t  readAddr2_i,
  input  archMapPkg::logReg_t  readAddr3_i,
  output archMapPkg::physReg_t readData0_o,
  output archMapPkg::physReg_t readData1_o,
  output archMapPkg::physReg_t readData2_o,
  output archMapPkg::physReg_t readData3_o,
  // write ports, take effect at the next edge.
  input  logic                 writeEn0_i,
  input  logic                 writeEn1_i,
  input  logic                 writeEn2_i,
  input  logic                 writeEn3_i,
  input  archMapPkg::logReg_t  writeLog0_i,
  input  archMapPkg::logReg_t  writeLog1_i,
  input  archMapPkg::logReg_t  writeLog2_i,
  input  archMapPkg::logReg_t  writeLog3_i,
  input  archMapPkg::physReg_t writePhys0_i,
  input  archMapPkg::physReg_t writePhys1_i,
  input  archMapPkg::physReg_t writePhys2_i,
  input  archMapPkg::physReg_t writePhys3_i
);

  archMapPkg::physReg_t mapTable [archMapPkg::NUM_LOGICAL];  // logical -> physical.

  // write ports gathered into arrays so one loop serves all four.
  logic                 wrEn   [archMapPkg::COMMIT_W];
  archMapPkg::logReg_t  wrLog  [archMapPkg::COMMIT_W];
  archMapPkg::physReg_t wrPhys [archMapPkg::COMMIT_W];
  logic                 writeClash;  // two enabled ports hit one entry.

  assign wrEn   = '{writeEn0_i, writeEn1_i, writeEn2_i, writeEn3_i};
  assign wrLog  = '{writeLog0_i, writeLog1_i, writeLog2_i, writeLog3_i};
  assign wrPhys = '{writePhys0_i, writePhys1_i, writePhys2_i, writePhys3_i};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < archMapPkg::NUM_LOGICAL; i++) begin
        mapTable[i] <= archMapPkg::physReg_t'(i);  // identity map.
      end
    end else begin
      for (int n = 0; n < archMapPkg::COMMIT_W; n++) begin
        if (wrEn[n]) mapTable[wrLog[n]] <= wrPhys[n];
      end
    end
  end

  assign readData0_o = mapTable[readAddr0_i];
  assign readData1_o = mapTable[readAddr1_i];
  assign readData2_o = mapTable[readAddr2_i];
  assign readData3_o = mapTable[readAddr3_i];

  // pairwise compare of the enabled write targets.
  always_comb begin
    writeClash = 1'b0;
    for (int a = 0; a < archMapPkg::COMMIT_W; a++) begin
      for (int b = a + 1; b < archMapPkg::COMMIT_W; b++) begin
        if (wrEn[a] && wrEn[b] && (wrLog[a] == wrLog[b])) writeClash = 1'b1;
      end
    end
  end

  // the commit filter leaves only the youngest writer per entry.
  noWriteClash: assert property (@(posedge clk) disable iff (reset) !writeClash)
    else $error("two write ports target one map entry");

endmodule

/* design/commitFilter.sv */
`timescale 1ns/10ps

module commitFilter (
  // retire window, slot 0 is oldest.
  input  logic                 commitValid0_i,
  input  logic                 commitValid1_i,
  input  logic                 commitValid2_i,
  input  logic                 commitValid3_i,
  input  archMapPkg::logReg_t  commitLog0_i,
  input  archMapPkg::logReg_t  commitLog1_i,
  input  archMapPkg::logReg_t  commitLog2_i,
  input  archMapPkg::logReg_t  commitLog3_i,
  input  archMapPkg::physReg_t commitPhys0_i,
  input  archMapPkg::physReg_t commitPhys1_i,
  input  archMapPkg::physReg_t commitPhys2_i,
  input  archMapPkg::physReg_t commitPhys3_i,
  // current table mapping of each slot's destination.
  input  archMapPkg::physReg_t oldPhys0_i,
  input  archMapPkg::physReg_t oldPhys1_i,
  input  archMapPkg::physReg_t oldPhys2_i,
  input  archMapPkg::physReg_t oldPhys3_i,
  // table write side.
  output logic                 writeEn0_o,
  output logic                 writeEn1_o,
  output logic                 writeEn2_o,
  output logic                 writeEn3_o,
  output archMapPkg::logReg_t  writeLog0_o,
  output archMapPkg::logReg_t  writeLog1_o,
  output archMapPkg::logReg_t  writeLog2_o,
  output archMapPkg::logReg_t  writeLog3_o,
  output archMapPkg::physReg_t writePhys0_o,
  output archMapPkg::physReg_t writePhys1_o,
  output archMapPkg::physReg_t writePhys2_o,
  output archMapPkg::physReg_t writePhys3_o,
  // register handed back to the free list.
  output archMapPkg::physReg_t releasedPhys0_o,
  output archMapPkg::physReg_t releasedPhys1_o,
  output archMapPkg::physReg_t releasedPhys2_o,
  output archMapPkg::physReg_t releasedPhys3_o
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // same-window compare
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic superseded0;  // a younger valid slot writes the same register.
  logic superseded1;
  logic superseded2;

  // only valid younger slots count. an invalid slot never hides an older one.
  assign superseded0 = (commitValid1_i && (commitLog0_i == commitLog1_i))
                    || (commitValid2_i && (commitLog0_i == commitLog2_i))
                    || (commitValid3_i && (commitLog0_i == commitLog3_i));
  assign superseded1 = (commitValid2_i && (commitLog1_i == commitLog2_i))
                    || (commitValid3_i && (commitLog1_i == commitLog3_i));
  assign superseded2 = commitValid3_i && (commitLog2_i == commitLog3_i);
  // slot 3 is youngest, nothing can supersede it.

  // write enables.
  assign writeEn0_o = commitValid0_i && !superseded0;
  assign writeEn1_o = commitValid1_i && !superseded1;
  assign writeEn2_o = commitValid2_i && !superseded2;
  assign writeEn3_o = commitValid3_i;

  assign writeLog0_o  = commitLog0_i;  // target is always the destination.
  assign writeLog1_o  = commitLog1_i;
  assign writeLog2_o  = commitLog2_i;
  assign writeLog3_o  = commitLog3_i;
  assign writePhys0_o = commitPhys0_i;
  assign writePhys1_o = commitPhys1_i;
  assign writePhys2_o = commitPhys2_i;
  assign writePhys3_o = commitPhys3_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // release select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a superseded slot frees its own register; the table's old one stays put
  // until the youngest writer of the window retires it.
  assign releasedPhys0_o = superseded0 ? commitPhys0_i : oldPhys0_i;
  assign releasedPhys1_o = superseded1 ? commitPhys1_i : oldPhys1_i;
  assign releasedPhys2_o = superseded2 ? commitPhys2_i : oldPhys2_i;
  assign releasedPhys3_o = oldPhys3_i;

endmodule

/* design/mapTableCtrl.sv */
`timescale 1ns/10ps

module mapTableCtrl (
  input  logic                clk,
  input  logic                reset,
  input  logic                recoverFlag_i,   // one-cycle strobe.
  input  logic                commitValid0_i,
  input  logic                commitValid1_i,
  input  logic                commitValid2_i,
  input  logic                commitValid3_i,
  input  archMapPkg::logReg_t commitLog0_i,
  input  archMapPkg::logReg_t commitLog1_i,
  input  archMapPkg::logReg_t commitLog2_i,
  input  archMapPkg::logReg_t commitLog3_i,
  output archMapPkg::logReg_t readAddr0_o,
  output archMapPkg::logReg_t readAddr1_o,
  output archMapPkg::logReg_t readAddr2_o,
  output archMapPkg::logReg_t readAddr3_o,
  output archMapPkg::logReg_t recoverLog0_o,
  output archMapPkg::logReg_t recoverLog1_o,
  output archMapPkg::logReg_t recoverLog2_o,
  output archMapPkg::logReg_t recoverLog3_o,
  output logic                recoverValid_o   // high for the whole walk.
);

  archMapPkg::walkState_t     walkState;
  archMapPkg::logReg_t        walkBase;   // first logical reg of this group.
  logic [archMapPkg::LOG_W:0] baseSum;    // next base plus carry out.
  logic                       walkLast;   // carry marks the final group.
  logic                       walking;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // walk fsm and base counter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // table depth is a power of two, so the carry fires after exactly
  // WALK_CYCLES steps of four.
  assign baseSum  = {1'b0, walkBase} + (archMapPkg::LOG_W + 1)'(archMapPkg::COMMIT_W);
  assign walkLast = baseSum[archMapPkg::LOG_W];
  assign walking  = (walkState == archMapPkg::WALK_RUN);

  always_ff @(posedge clk) begin
    if (reset) begin
      walkState <= archMapPkg::WALK_IDLE;
      walkBase  <= '0;
    end else begin
      case (walkState)
        archMapPkg::WALK_IDLE: begin
          if (recoverFlag_i) begin
            walkState <= archMapPkg::WALK_RUN;
            walkBase  <= '0;  // walk starts at logical 0.
          end
        end
        archMapPkg::WALK_RUN: begin  // strobes here are ignored.
          walkBase <= baseSum[archMapPkg::LOG_W-1:0];  // wraps back to 0.
          if (walkLast) walkState <= archMapPkg::WALK_IDLE;
        end
        default: walkState <= archMapPkg::WALK_IDLE;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address steering
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // base is a multiple of four, so the sums never carry.
  assign recoverLog0_o = walkBase;
  assign recoverLog1_o = walkBase + archMapPkg::logReg_t'(1);
  assign recoverLog2_o = walkBase + archMapPkg::logReg_t'(2);
  assign recoverLog3_o = walkBase + archMapPkg::logReg_t'(3);
  assign recoverValid_o = walking;

  assign readAddr0_o = walking ? recoverLog0_o : commitLog0_i;  // idle reads old maps.
  assign readAddr1_o = walking ? recoverLog1_o : commitLog1_i;
  assign readAddr2_o = walking ? recoverLog2_o : commitLog2_i;
  assign readAddr3_o = walking ? recoverLog3_o : commitLog3_i;

  // the active list holds retirement off until the walk is done.
  noCommitInWalk: assert property (@(posedge clk) disable iff (reset)
    walking |-> !(commitValid0_i || commitValid1_i || commitValid2_i || commitValid3_i))
    else $error("commit valid during recovery walk");

  walkLength: assert property (@(posedge clk) disable iff (reset)
    (!walking && recoverFlag_i) |=> walking [*archMapPkg::WALK_CYCLES] ##1 !walking)
    else $error("recovery walk length is not WALK_CYCLES");

endmodule

/* design/archMapTable.sv */
`timescale 1ns/10ps

module archMapTable (
  input  logic                 clk,
  input  logic                 reset,
  // retiring instructions from the active list, slot 0 oldest.
  input  logic                 commitValid0_i,
  input  archMapPkg::logReg_t  commitLog0_i,
  input  archMapPkg::physReg_t commitPhys0_i,
  input  logic                 commitValid1_i,
  input  archMapPkg::logReg_t  commitLog1_i,
  input  archMapPkg::physReg_t commitPhys1_i,
  input  logic                 commitValid2_i,
  input  archMapPkg::logReg_t  commitLog2_i,
  input  archMapPkg::physReg_t commitPhys2_i,
  input  logic                 commitValid3_i,
  input  archMapPkg::logReg_t  commitLog3_i,
  input  archMapPkg::physReg_t commitPhys3_i,
  input  logic                 recoverFlag_i,  // mispredict or exception.
  // to the free list.
  output logic                 releasedValid0_o,
  output archMapPkg::physReg_t releasedPhys0_o,
  output logic                 releasedValid1_o,
  output archMapPkg::physReg_t releasedPhys1_o,
  output logic                 releasedValid2_o,
  output archMapPkg::physReg_t releasedPhys2_o,
  output logic                 releasedValid3_o,
  output archMapPkg::physReg_t releasedPhys3_o,
  // to the rename map table.
  output archMapPkg::logReg_t  recoverLog0_o,
  output archMapPkg::physReg_t recoverPhys0_o,
  output archMapPkg::logReg_t  recoverLog1_o,
  output archMapPkg::physReg_t recoverPhys1_o,
  output archMapPkg::logReg_t  recoverLog2_o,
  output archMapPkg::physReg_t recoverPhys2_o,
  output archMapPkg::logReg_t  recoverLog3_o,
  output archMapPkg::physReg_t recoverPhys3_o,
  output logic                 recoverValid_o
);

  archMapPkg::logReg_t  readAddr0, readAddr1, readAddr2, readAddr3;
  archMapPkg::physReg_t readData0, readData1, readData2, readData3;
  logic                 writeEn0, writeEn1, writeEn2, writeEn3;
  archMapPkg::logReg_t  writeLog0, writeLog1, writeLog2, writeLog3;
  archMapPkg::physReg_t writePhys0, writePhys1, writePhys2, writePhys3;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // blocks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  mapTableCtrl mapTableCtrl_inst (
    .clk(clk), .reset(reset), .recoverFlag_i(recoverFlag_i),
    .commitValid0_i(commitValid0_i), .commitValid1_i(commitValid1_i),
    .commitValid2_i(commitValid2_i), .commitValid3_i(commitValid3_i),
    .commitLog0_i(commitLog0_i), .commitLog1_i(commitLog1_i),
    .commitLog2_i(commitLog2_i), .commitLog3_i(commitLog3_i),
    .readAddr0_o(readAddr0), .readAddr1_o(readAddr1),
    .readAddr2_o(readAddr2), .readAddr3_o(readAddr3),
    .recoverLog0_o(recoverLog0_o), .recoverLog1_o(recoverLog1_o),
    .recoverLog2_o(recoverLog2_o), .recoverLog3_o(recoverLog3_o),
    .recoverValid_o(recoverValid_o)
  );

  commitFilter commitFilter_inst (
    .commitValid0_i(commitValid0_i), .commitValid1_i(commitValid1_i),
    .commitValid2_i(commitValid2_i), .commitValid3_i(commitValid3_i),
    .commitLog0_i(commitLog0_i), .commitLog1_i(commitLog1_i),
    .commitLog2_i(commitLog2_i), .commitLog3_i(commitLog3_i),
    .commitPhys0_i(commitPhys0_i), .commitPhys1_i(commitPhys1_i),
    .commitPhys2_i(commitPhys2_i), .commitPhys3_i(commitPhys3_i),
    .oldPhys0_i(readData0), .oldPhys1_i(readData1),      // old mappings.
    .oldPhys2_i(readData2), .oldPhys3_i(readData3),
    .writeEn0_o(writeEn0), .writeEn1_o(writeEn1),
    .writeEn2_o(writeEn2), .writeEn3_o(writeEn3),
    .writeLog0_o(writeLog0), .writeLog1_o(writeLog1),
    .writeLog2_o(writeLog2), .writeLog3_o(writeLog3),
    .writePhys0_o(writePhys0), .writePhys1_o(writePhys1),
    .writePhys2_o(writePhys2), .writePhys3_o(writePhys3),
    .releasedPhys0_o(releasedPhys0_o), .releasedPhys1_o(releasedPhys1_o),
    .releasedPhys2_o(releasedPhys2_o), .releasedPhys3_o(releasedPhys3_o)
  );

  archMapRam archMapRam_inst (
    .clk(clk), .reset(reset),
    .readAddr0_i(readAddr0), .readAddr1_i(readAddr1),
    .readAddr2_i(readAddr2), .readAddr3_i(readAddr3),
    .readData0_o(readData0), .readData1_o(readData1),
    .readData2_o(readData2), .readData3_o(readData3),
    .writeEn0_i(writeEn0), .writeEn1_i(writeEn1),
    .writeEn2_i(writeEn2), .writeEn3_i(writeEn3),
    .writeLog0_i(writeLog0), .writeLog1_i(writeLog1),
    .writeLog2_i(writeLog2), .writeLog3_i(writeLog3),
    .writePhys0_i(writePhys0), .writePhys1_i(writePhys1),
    .writePhys2_i(writePhys2), .writePhys3_i(writePhys3)
  );

  // every valid commit frees exactly one register.
  assign releasedValid0_o = commitValid0_i;
  assign releasedValid1_o = commitValid1_i;
  assign releasedValid2_o = commitValid2_i;
  assign releasedValid3_o = commitValid3_i;

  assign recoverPhys0_o = readData0;  // walk data, valid with recoverValid_o.
  assign recoverPhys1_o = readData1;
  assign recoverPhys2_o = readData2;
  assign recoverPhys3_o = readData3;

endmodule

/* test/archMapTableTb.sv */
`timescale 1ns/10ps

module archMapTableTb;

  localparam int RESET_CYCLES   = 5;
  localparam int NUM_TESTS      = 6;
  localparam int TEST_CYCLES    = 16;   // upper bound for one directed test.
  localparam int RANDOM_WINDOWS = 200;
  // every test plus the random windows, then a margin.
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_TESTS * TEST_CYCLES + RANDOM_WINDOWS + 50;
  localparam logic [15:0] LFSR_SEED = 16'd83;

  logic                 clk;
  logic                 reset;
  logic                 recoverFlag;
  logic                 commitValid [archMapPkg::COMMIT_W];  // slot 0 oldest.
  archMapPkg::logReg_t  commitLog   [archMapPkg::COMMIT_W];
  archMapPkg::physReg_t commitPhys  [archMapPkg::COMMIT_W];
  logic                 relValid    [archMapPkg::COMMIT_W];
  archMapPkg::physReg_t relPhys     [archMapPkg::COMMIT_W];
  archMapPkg::logReg_t  recLog      [archMapPkg::COMMIT_W];
  archMapPkg::physReg_t recPhys     [archMapPkg::COMMIT_W];
  logic                 recoverValid;

  archMapPkg::physReg_t model [archMapPkg::NUM_LOGICAL];  // expected table.
  logic                 hidden      [archMapPkg::COMMIT_W];  // younger valid writer.
  archMapPkg::physReg_t expReleased [archMapPkg::COMMIT_W];
  archMapPkg::logReg_t  expWalkLog  [archMapPkg::COMMIT_W];
  archMapPkg::physReg_t expWalkPhys [archMapPkg::COMMIT_W];
  logic                 expWalking;
  int                   walkIdx;     // group number inside the walk.

  logic [15:0] lfsrState = LFSR_SEED;
  int cycleCount  = 0;
  int errCount    = 0;
  int errAtStart  = 0;
  int testNum     = 0;
  int testsPassed = 0;
  int testsFailed = 0;

  archMapTable archMapTable_inst (
    .clk(clk), .reset(reset), .recoverFlag_i(recoverFlag),
    .commitValid0_i(commitValid[0]), .commitLog0_i(commitLog[0]), .commitPhys0_i(commitPhys[0]),
    .commitValid1_i(commitValid[1]), .commitLog1_i(commitLog[1]), .commitPhys1_i(commitPhys[1]),
    .commitValid2_i(commitValid[2]), .commitLog2_i(commitLog[2]), .commitPhys2_i(commitPhys[2]),
    .commitValid3_i(commitValid[3]), .commitLog3_i(commitLog[3]), .commitPhys3_i(commitPhys[3]),
    .releasedValid0_o(relValid[0]), .releasedPhys0_o(relPhys[0]),
    .releasedValid1_o(relValid[1]), .releasedPhys1_o(relPhys[1]),
    .releasedValid2_o(relValid[2]), .releasedPhys2_o(relPhys[2]),
    .releasedValid3_o(relValid[3]), .releasedPhys3_o(relPhys[3]),
    .recoverLog0_o(recLog[0]), .recoverPhys0_o(recPhys[0]),
    .recoverLog1_o(recLog[1]), .recoverPhys1_o(recPhys[1]),
    .recoverLog2_o(recLog[2]), .recoverPhys2_o(recPhys[2]),
    .recoverLog3_o(recLog[3]), .recoverPhys3_o(recPhys[3]),
    .recoverValid_o(recoverValid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period.
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < archMapPkg::NUM_LOGICAL; i++) model[i] <= archMapPkg::physReg_t'(i);
    end else begin
      for (int n = 0; n < archMapPkg::COMMIT_W; n++) begin
        if (commitValid[n]) model[commitLog[n]] <= commitPhys[n];  // later slot wins.
      end
    end
  end

  // superseded slot frees its own reg, others free the current mapping.
  always_comb begin
    for (int n = 0; n < archMapPkg::COMMIT_W; n++) begin
      hidden[n] = 1'b0;
      for (int m = n + 1; m < archMapPkg::COMMIT_W; m++) begin
        if (commitValid[m] && (commitLog[m] == commitLog[n])) hidden[n] = 1'b1;
      end
      expReleased[n] = hidden[n] ? commitPhys[n] : model[commitLog[n]];
      expWalkLog[n]  = archMapPkg::logReg_t'(walkIdx * archMapPkg::COMMIT_W + n);
      expWalkPhys[n] = model[expWalkLog[n]];
    end
  end

  // walk starts on a strobe seen while idle, lasts WALK_CYCLES.
  always_ff @(posedge clk) begin
    if (reset) begin
      expWalking <= 1'b0;
      walkIdx    <= 0;
    end else if (!expWalking) begin
      if (recoverFlag) begin
        expWalking <= 1'b1;
        walkIdx    <= 0;
      end
    end else if (walkIdx == archMapPkg::WALK_CYCLES - 1) begin
      expWalking <= 1'b0;  // last group sent.
    end else begin
      walkIdx <= walkIdx + 1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic reportFail(input string msg);
    $display("Fail at %0d ns: %s", $time, msg);
    errCount++;
  endtask

  walkValidMatch: assert property (@(posedge clk) disable iff (reset) recoverValid == expWalking)
    else reportFail($sformatf("recover valid is %0b, expected %0b",
                              $sampled(recoverValid), $sampled(expWalking)));

  for (genvar n = 0; n < archMapPkg::COMMIT_W; n++) begin : slotChecks
    releaseValidMatch: assert property (@(posedge clk) disable iff (reset)
      relValid[n] == commitValid[n])
      else reportFail($sformatf("slot %0d release valid differs from commit valid", n));
    releasePhysMatch: assert property (@(posedge clk) disable iff (reset)
      commitValid[n] |-> relPhys[n] == expReleased[n])
      else reportFail($sformatf("slot %0d released p%0d, expected p%0d",
                                n, $sampled(relPhys[n]), $sampled(expReleased[n])));
    walkLogMatch: assert property (@(posedge clk) disable iff (reset)
      expWalking |-> recLog[n] == expWalkLog[n])
      else reportFail($sformatf("walk slot %0d logical r%0d, expected r%0d",
                                n, $sampled(recLog[n]), $sampled(expWalkLog[n])));
    walkPhysMatch: assert property (@(posedge clk) disable iff (reset)
      expWalking |-> recPhys[n] == expWalkPhys[n])
      else reportFail($sformatf("walk r%0d maps to p%0d, expected p%0d",
                                $sampled(recLog[n]), $sampled(recPhys[n]),
                                $sampled(expWalkPhys[n])));
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [15:0] nextLfsr(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // x^16+x^14+x^13+x^11+1.
  endfunction

  task automatic randomBits(input int width, output logic [7:0] value);
    value = '0;
    for (int b = 0; b < width; b++) begin
      lfsrState = nextLfsr(lfsrState);  // one step per bit.
      value = {value[6:0], lfsrState[0]};
    end
  endtask

  task automatic driveSlot(input logic [1:0] slot, input logic valid,
                           input archMapPkg::logReg_t log, input archMapPkg::physReg_t phys);
    commitValid[slot] <= valid;
    commitLog[slot]   <= log;
    commitPhys[slot]  <= phys;
  endtask

  // next edge, all slots idle unless the caller drives them.
  task automatic startWindow();
    @(posedge clk);
    for (int n = 0; n < archMapPkg::COMMIT_W; n++) commitValid[n] <= 1'b0;
  endtask

  task automatic endWindow();
    @(posedge clk);
    for (int n = 0; n < archMapPkg::COMMIT_W; n++) commitValid[n] <= 1'b0;
  endtask

  // strobe, optionally strobe again mid walk, then wait for the fall.
  task automatic recoverAndWait(input logic retrigger);
    @(posedge clk);
    recoverFlag <= 1'b1;
    @(posedge clk);
    recoverFlag <= 1'b0;
    if (retrigger) begin
      repeat (3) @(posedge clk);
      recoverFlag <= 1'b1;  // ignored by a running walk.
      @(posedge clk);
      recoverFlag <= 1'b0;
    end
    @(negedge clk);
    while (recoverValid) @(negedge clk);
  endtask

  task automatic beginTest();
    testNum++;
    errAtStart = errCount;
  endtask

  task automatic finishTest(input string name);
    repeat (2) @(posedge clk);
    @(negedge clk);  // checks of the last edge are done.
    if (errCount == errAtStart) begin
      testsPassed++;
      $display("test %0d %s: ok", testNum, name);
    end else begin
      testsFailed++;
      $display("test %0d %s: %0d errors", testNum, name, errCount - errAtStart);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    logic [7:0] v;
    logic [7:0] l;
    logic [7:0] p;
    reset = 1'b1;
    recoverFlag = 1'b0;
    for (int n = 0; n < archMapPkg::COMMIT_W; n++) begin
      commitValid[n] = 1'b0;
      commitLog[n]   = '0;
      commitPhys[n]  = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    beginTest();
    recoverAndWait(1'b0);  // identity map, ascending groups.
    finishTest("identity walk after reset");

    beginTest();
    startWindow();
    driveSlot(2'd2, 1'b1, 5'd3, 7'd100);
    endWindow();
    recoverAndWait(1'b0);
    finishTest("single commit");

    beginTest();
    startWindow();
    driveSlot(2'd0, 1'b1, 5'd9, 7'd50);  // three writers of r9.
    driveSlot(2'd1, 1'b1, 5'd9, 7'd51);
    driveSlot(2'd2, 1'b1, 5'd10, 7'd52);
    driveSlot(2'd3, 1'b1, 5'd9, 7'd53);
    startWindow();
    driveSlot(2'd0, 1'b1, 5'd12, 7'd60);
    driveSlot(2'd1, 1'b1, 5'd3, 7'd62);  // frees p100 from before.
    driveSlot(2'd2, 1'b1, 5'd12, 7'd61);
    endWindow();
    recoverAndWait(1'b0);
    finishTest("same window destinations");

    beginTest();
    startWindow();
    driveSlot(2'd0, 1'b0, 5'd5, 7'd39);  // invalid, collides with slot 1.
    driveSlot(2'd1, 1'b1, 5'd5, 7'd40);
    driveSlot(2'd2, 1'b0, 5'd5, 7'd41);  // invalid younger, must not hide slot 1.
    driveSlot(2'd3, 1'b0, 5'd9, 7'd42);
    endWindow();
    recoverAndWait(1'b0);
    finishTest("invalid slots");

    beginTest();
    for (int w = 0; w < RANDOM_WINDOWS; w++) begin
      startWindow();
      for (int n = 0; n < archMapPkg::COMMIT_W; n++) begin
        randomBits(1, v);
        randomBits(archMapPkg::LOG_W, l);
        randomBits(archMapPkg::PHYS_W, p);
        driveSlot(2'(n), v[0], l[archMapPkg::LOG_W-1:0], p[archMapPkg::PHYS_W-1:0]);
      end
    end
    endWindow();
    recoverAndWait(1'b0);
    finishTest("random windows");

    beginTest();
    recoverAndWait(1'b1);
    finishTest("strobe during walk");

    $display("tests %0d, passed %0d, failed %0d, check failures %0d",
             testNum, testsPassed, testsFailed, errCount);
    if (errCount == 0 && testsFailed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
design/archMapPkg.sv
design/archMapRam.sv
design/commitFilter.sv
design/mapTableCtrl.sv
design/archMapTable.sv
test/archMapTableTb.sv

/* run.sh */
#!/bin/sh
# compile and run the archMapTable testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --timescale 1ns/10ps \
  --top-module archMapTableTb \
  -f verilog.f \
  -o archMapTableSim

./obj_dir/archMapTableSim | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
